// ==== vlog.f ====
bridge_pkg.sv
async_fifo.sv
cdc_channel.sv
master_axi_async.sv
tb_master_axi_async.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f \
    --top-module tb_master_axi_async -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

if echo "$output" | grep -q "Simulation PASSED"; then
    exit 0
fi
exit 1

// ==== tb_master_axi_async.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_master_axi_async import bridge_pkg::*; ();

    localparam int ROWS       = 8;
    localparam int BP_ROWS    = 12;
    localparam int TOTAL_ROWS = 4 * ROWS + BP_ROWS;
    localparam real BUS_PER   = 40.0;

    logic BUS_CLK, BUS_RST, MASTER_CLK, MASTER_RST;
    addr_req_t mst_wr_addr, mst_rd_addr, bus_wr_addr, bus_rd_addr;
    wr_beat_t  mst_wr_data, bus_wr_data;
    rd_beat_t  mst_rd_data, bus_rd_data;
    logic mst_wr_addr_valid, mst_wr_addr_ready, mst_wr_data_valid, mst_wr_data_ready;
    logic mst_rd_addr_valid, mst_rd_addr_ready, mst_rd_data_valid, mst_rd_data_ready;
    logic bus_wr_addr_valid, bus_wr_addr_ready, bus_wr_data_valid, bus_wr_data_ready;
    logic bus_rd_addr_valid, bus_rd_addr_ready, bus_rd_data_valid, bus_rd_data_ready;

    // Stimulus table with one array per channel
    addr_req_t wa_tab [ROWS];
    wr_beat_t  wd_tab [ROWS];
    addr_req_t ra_tab [ROWS];
    rd_beat_t  rd_tab [ROWS];
    addr_req_t bp_tab [BP_ROWS];

    addr_req_t wa_exp [$];
    wr_beat_t  wd_exp [$];
    addr_req_t ra_exp [$];
    rd_beat_t  rd_exp [$];

    int seed, mismatches, other_errors;
    int wa_in, wa_out, wd_in, wd_out, ra_in, ra_out, rd_in, rd_out;
    logic hold_wa_ready;
    logic wa_stall, wd_stall, ra_stall, rd_stall;
    addr_req_t wa_prev, ra_prev;
    wr_beat_t  wd_prev;
    rd_beat_t  rd_prev;

    master_axi_async dut_i (.*);

    always #(BUS_PER / 2) BUS_CLK = ~BUS_CLK;
    always #15 MASTER_CLK = ~MASTER_CLK;

    task automatic report_error(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        mismatches++;
    endtask

    task automatic build_table();
        for (int i = 0; i < ROWS; i++) begin
            wa_tab[i].addr = 32'h1000_0000 + i * 32'h40;
            wa_tab[i].len  = 8'd3;
            wa_tab[i].id   = i[1:0];
            wd_tab[i].id   = i[3:2];
            wd_tab[i].strb = 4'hf ^ i[3:0];
            // Bursts of four beats, last on the fourth
            wd_tab[i].last = (i % 4 == 3);
            wd_tab[i].data = 32'ha5a5_0000 ^ (i * 32'h0101_0101);
            ra_tab[i].addr = 32'h2000_0000 + i * 32'h100;
            ra_tab[i].len  = i[7:0];
            ra_tab[i].id   = ~i[1:0];
            rd_tab[i].id   = i[2:1];
            rd_tab[i].last = (i % 4 == 3);
            rd_tab[i].data = 32'h5a5a_0000 + i * 32'h11;
        end
        for (int i = 0; i < BP_ROWS; i++) begin
            bp_tab[i].addr = 32'h3000_0000 + i * 4;
            bp_tab[i].len  = 8'd0;
            bp_tab[i].id   = i[1:0];
        end
    endtask

    // Each send starts just after a clock edge and returns on the accepting edge
    task automatic send_wr_addr(input addr_req_t r);
        #1;
        mst_wr_addr = r;
        mst_wr_addr_valid = 1'b1;
        do @(posedge MASTER_CLK); while (!mst_wr_addr_ready);
        wa_exp.push_back(r);
        wa_in++;
    endtask

    task automatic send_wr_data(input wr_beat_t b);
        #1;
        mst_wr_data = b;
        mst_wr_data_valid = 1'b1;
        do @(posedge MASTER_CLK); while (!mst_wr_data_ready);
        wd_exp.push_back(b);
        wd_in++;
    endtask

    task automatic send_rd_addr(input addr_req_t r);
        #1;
        mst_rd_addr = r;
        mst_rd_addr_valid = 1'b1;
        do @(posedge MASTER_CLK); while (!mst_rd_addr_ready);
        ra_exp.push_back(r);
        ra_in++;
    endtask

    task automatic send_rd_beat(input rd_beat_t b);
        #1;
        bus_rd_data = b;
        bus_rd_data_valid = 1'b1;
        do @(posedge BUS_CLK); while (!bus_rd_data_ready);
        rd_exp.push_back(b);
        rd_in++;
    endtask

    task automatic wait_drained();
        while (wa_exp.size() + wd_exp.size() + ra_exp.size() + rd_exp.size() != 0) begin
            @(posedge BUS_CLK);
        end
        repeat (20) @(posedge BUS_CLK);
    endtask

    // Random sinks
    always @(posedge BUS_CLK) begin
        #1;
        bus_wr_addr_ready = hold_wa_ready ? 1'b0 : 1'($random(seed));
        bus_wr_data_ready = 1'($random(seed));
        bus_rd_addr_ready = 1'($random(seed));
    end

    always @(posedge MASTER_CLK) begin
        #1;
        mst_rd_data_ready = 1'($random(seed));
    end

    // Bus side monitors
    always @(posedge BUS_CLK) begin
        if (!BUS_RST) begin
            if (bus_wr_addr_valid && bus_wr_addr_ready) begin
                wa_out++;
                if (wa_exp.size() == 0) begin
                    $display("Unexpected write address transfer at %0t ns", $time);
                    other_errors++;
                end else if (bus_wr_addr !== wa_exp[0]) begin
                    report_error($sformatf("wr_addr got %h exp %h", bus_wr_addr, wa_exp[0]));
                end
                if (wa_exp.size() != 0) void'(wa_exp.pop_front());
            end
            if (bus_wr_data_valid && bus_wr_data_ready) begin
                wd_out++;
                if (wd_exp.size() == 0) begin
                    $display("Unexpected write data transfer at %0t ns", $time);
                    other_errors++;
                end else if (bus_wr_data !== wd_exp[0]) begin
                    report_error($sformatf("wr_data got %h exp %h", bus_wr_data, wd_exp[0]));
                end
                if (wd_exp.size() != 0) void'(wd_exp.pop_front());
            end
            if (bus_rd_addr_valid && bus_rd_addr_ready) begin
                ra_out++;
                if (ra_exp.size() == 0) begin
                    $display("Unexpected read address transfer at %0t ns", $time);
                    other_errors++;
                end else if (bus_rd_addr !== ra_exp[0]) begin
                    report_error($sformatf("rd_addr got %h exp %h", bus_rd_addr, ra_exp[0]));
                end
                if (ra_exp.size() != 0) void'(ra_exp.pop_front());
            end
            // A stalled item must stay put
            if (wa_stall && (!bus_wr_addr_valid || bus_wr_addr !== wa_prev)) begin
                report_error("wr_addr changed while stalled");
            end
            if (wd_stall && (!bus_wr_data_valid || bus_wr_data !== wd_prev)) begin
                report_error("wr_data changed while stalled");
            end
            if (ra_stall && (!bus_rd_addr_valid || bus_rd_addr !== ra_prev)) begin
                report_error("rd_addr changed while stalled");
            end
        end
        wa_stall = bus_wr_addr_valid && !bus_wr_addr_ready;
        wd_stall = bus_wr_data_valid && !bus_wr_data_ready;
        ra_stall = bus_rd_addr_valid && !bus_rd_addr_ready;
        wa_prev  = bus_wr_addr;
        wd_prev  = bus_wr_data;
        ra_prev  = bus_rd_addr;
    end

    // Master side read data monitor
    always @(posedge MASTER_CLK) begin
        if (!MASTER_RST) begin
            if (mst_rd_data_valid && mst_rd_data_ready) begin
                rd_out++;
                if (rd_exp.size() == 0) begin
                    $display("Unexpected read data transfer at %0t ns", $time);
                    other_errors++;
                end else if (mst_rd_data !== rd_exp[0]) begin
                    report_error($sformatf("rd_data got %h exp %h", mst_rd_data, rd_exp[0]));
                end
                if (rd_exp.size() != 0) void'(rd_exp.pop_front());
            end
            if (rd_stall && (!mst_rd_data_valid || mst_rd_data !== rd_prev)) begin
                report_error("rd_data changed while stalled");
            end
        end
        rd_stall = mst_rd_data_valid && !mst_rd_data_ready;
        rd_prev  = mst_rd_data;
    end

    // Watchdog
    initial begin
        #(TOTAL_ROWS * 200 * BUS_PER);
        $display("Timeout: the run did not finish in time");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        BUS_CLK = 1'b0;
        MASTER_CLK = 1'b0;
        BUS_RST = 1'b1;
        MASTER_RST = 1'b1;
        mst_wr_addr = '0;
        mst_wr_data = '0;
        mst_rd_addr = '0;
        bus_rd_data = '0;
        mst_wr_addr_valid = 1'b0;
        mst_wr_data_valid = 1'b0;
        mst_rd_addr_valid = 1'b0;
        bus_rd_data_valid = 1'b0;
        bus_wr_addr_ready = 1'b0;
        bus_wr_data_ready = 1'b0;
        bus_rd_addr_ready = 1'b0;
        mst_rd_data_ready = 1'b0;
        hold_wa_ready = 1'b0;
        seed = 51;
        build_table();

        repeat (4) @(posedge BUS_CLK);
        #1;
        BUS_RST = 1'b0;
        MASTER_RST = 1'b0;

        // Nothing valid before any input
        repeat (10) begin
            @(posedge BUS_CLK);
            if (bus_wr_addr_valid || bus_wr_data_valid || bus_rd_addr_valid ||
                mst_rd_data_valid) begin
                report_error("valid output high before any input transfer");
            end
        end

        fork
            begin
                @(posedge MASTER_CLK);
                for (int i = 0; i < ROWS; i++) send_wr_addr(wa_tab[i]);
                #1 mst_wr_addr_valid = 1'b0;
            end
            begin
                @(posedge MASTER_CLK);
                for (int i = 0; i < ROWS; i++) send_wr_data(wd_tab[i]);
                #1 mst_wr_data_valid = 1'b0;
            end
            begin
                @(posedge MASTER_CLK);
                for (int i = 0; i < ROWS; i++) send_rd_addr(ra_tab[i]);
                #1 mst_rd_addr_valid = 1'b0;
            end
            begin
                @(posedge BUS_CLK);
                for (int i = 0; i < ROWS; i++) send_rd_beat(rd_tab[i]);
                #1 bus_rd_data_valid = 1'b0;
            end
        join
        wait_drained();

        // Capacity under backpressure is the FIFO depth plus the held item
        hold_wa_ready = 1'b1;
        repeat (2) @(posedge BUS_CLK);
        fork
            begin
                @(posedge MASTER_CLK);
                for (int i = 0; i < BP_ROWS; i++) send_wr_addr(bp_tab[i]);
                #1 mst_wr_addr_valid = 1'b0;
            end
            begin
                wait (wa_in >= ROWS + (1 << FIFO_DEPTH_LOG2) + 1);
                repeat (40) @(posedge MASTER_CLK);
                if (wa_in != ROWS + (1 << FIFO_DEPTH_LOG2) + 1 || mst_wr_addr_ready) begin
                    report_error($sformatf("backpressure accepted %0d, ready %b",
                                           wa_in - ROWS, mst_wr_addr_ready));
                end
                hold_wa_ready = 1'b0;
            end
        join
        wait_drained();

        if (wa_in != wa_out || wd_in != wd_out || ra_in != ra_out || rd_in != rd_out) begin
            report_error("item counts in and out differ");
        end
        $display("Errors: %0d check failures, %0d other failures", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== master_axi_async.sv ====
`timescale 1ns/100ps
`default_nettype none

module master_axi_async import bridge_pkg::*; (
    input  wire            BUS_CLK,
    input  wire            BUS_RST,
    input  wire            MASTER_CLK,
    input  wire            MASTER_RST,

    // Master side
    input  wire addr_req_t mst_wr_addr,
    input  wire            mst_wr_addr_valid,
    output wire            mst_wr_addr_ready,

    input  wire wr_beat_t  mst_wr_data,
    input  wire            mst_wr_data_valid,
    output wire            mst_wr_data_ready,

    input  wire addr_req_t mst_rd_addr,
    input  wire            mst_rd_addr_valid,
    output wire            mst_rd_addr_ready,

    output wire rd_beat_t  mst_rd_data,
    output wire            mst_rd_data_valid,
    input  wire            mst_rd_data_ready,

    // Bus side
    output wire addr_req_t bus_wr_addr,
    output wire            bus_wr_addr_valid,
    input  wire            bus_wr_addr_ready,

    output wire wr_beat_t  bus_wr_data,
    output wire            bus_wr_data_valid,
    input  wire            bus_wr_data_ready,

    output wire addr_req_t bus_rd_addr,
    output wire            bus_rd_addr_valid,
    input  wire            bus_rd_addr_ready,

    input  wire rd_beat_t  bus_rd_data,
    input  wire            bus_rd_data_valid,
    output wire            bus_rd_data_ready
);

    // Master to bus
    cdc_channel #(.WIDTH($bits(addr_req_t))) wr_addr_ch (
        .in_clk      (MASTER_CLK),
        .in_rst      (MASTER_RST),
        .in_payload  (mst_wr_addr),
        .in_valid    (mst_wr_addr_valid),
        .in_ready    (mst_wr_addr_ready),
        .out_clk     (BUS_CLK),
        .out_rst     (BUS_RST),
        .out_payload (bus_wr_addr),
        .out_valid   (bus_wr_addr_valid),
        .out_ready   (bus_wr_addr_ready)
    );

    cdc_channel #(.WIDTH($bits(wr_beat_t))) wr_data_ch (
        .in_clk      (MASTER_CLK),
        .in_rst      (MASTER_RST),
        .in_payload  (mst_wr_data),
        .in_valid    (mst_wr_data_valid),
        .in_ready    (mst_wr_data_ready),
        .out_clk     (BUS_CLK),
        .out_rst     (BUS_RST),
        .out_payload (bus_wr_data),
        .out_valid   (bus_wr_data_valid),
        .out_ready   (bus_wr_data_ready)
    );

    cdc_channel #(.WIDTH($bits(addr_req_t))) rd_addr_ch (
        .in_clk      (MASTER_CLK),
        .in_rst      (MASTER_RST),
        .in_payload  (mst_rd_addr),
        .in_valid    (mst_rd_addr_valid),
        .in_ready    (mst_rd_addr_ready),
        .out_clk     (BUS_CLK),
        .out_rst     (BUS_RST),
        .out_payload (bus_rd_addr),
        .out_valid   (bus_rd_addr_valid),
        .out_ready   (bus_rd_addr_ready)
    );

    // Read data runs the other way from bus to master
    cdc_channel #(.WIDTH($bits(rd_beat_t))) rd_data_ch (
        .in_clk      (BUS_CLK),
        .in_rst      (BUS_RST),
        .in_payload  (bus_rd_data),
        .in_valid    (bus_rd_data_valid),
        .in_ready    (bus_rd_data_ready),
        .out_clk     (MASTER_CLK),
        .out_rst     (MASTER_RST),
        .out_payload (mst_rd_data),
        .out_valid   (mst_rd_data_valid),
        .out_ready   (mst_rd_data_ready)
    );

endmodule

`default_nettype wire

// ==== cdc_channel.sv ====
`timescale 1ns/100ps
`default_nettype none

module cdc_channel import bridge_pkg::*; #(
    parameter int WIDTH = 32
) (
    input  wire              in_clk,
    input  wire              in_rst,
    input  wire  [WIDTH-1:0] in_payload,
    input  wire              in_valid,
    output wire              in_ready,

    input  wire              out_clk,
    input  wire              out_rst,
    output wire  [WIDTH-1:0] out_payload,
    output wire              out_valid,
    input  wire              out_ready
);

    out_state_e state;

    logic fifo_wr_en;
    logic fifo_wr_full;
    logic fifo_rd_en;
    logic fifo_rd_empty;

    // Input side
    assign in_ready   = !fifo_wr_full && !in_rst;
    assign fifo_wr_en = in_valid && in_ready;

    async_fifo #(
        .WIDTH      (WIDTH),
        .DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) fifo_i (
        .wr_clk   (in_clk),
        .wr_rst   (in_rst),
        .wr_en    (fifo_wr_en),
        .wr_data  (in_payload),
        .wr_full  (fifo_wr_full),
        .rd_clk   (out_clk),
        .rd_rst   (out_rst),
        .rd_en    (fifo_rd_en),
        .rd_data  (out_payload),
        .rd_empty (fifo_rd_empty)
    );

    // Fetch when the stage is free or its word leaves this cycle
    assign out_valid  = (state == OUT_HOLD);
    assign fifo_rd_en = !fifo_rd_empty && ((state == OUT_EMPTY) || (out_valid && out_ready));

    always_ff @(posedge out_clk) begin
        if (out_rst) begin
            state <= OUT_EMPTY;
        end else begin
            case (state)
                OUT_EMPTY: begin
                    if (fifo_rd_en) begin
                        state <= OUT_HOLD;
                    end
                end
                OUT_HOLD: begin
                    // No refill available
                    if (out_ready && !fifo_rd_en) begin
                        state <= OUT_EMPTY;
                    end
                end
                default: state <= OUT_EMPTY;
            endcase
        end
    end

    a_hold_stable: assert property (
        @(posedge out_clk) disable iff (out_rst)
        (state == OUT_HOLD && !out_ready) |=> (state == OUT_HOLD && $stable(out_payload))
    ) else $error("cdc_channel payload changed while stalled");

    a_no_valid_in_reset: assert property (
        @(posedge out_clk) out_rst |=> !out_valid
    ) else $error("cdc_channel out_valid high after out_rst");

endmodule

`default_nettype wire

// ==== async_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module async_fifo #(
    parameter int WIDTH      = 32,
    parameter int DEPTH_LOG2 = 3
) (
    input  wire              wr_clk,
    input  wire              wr_rst,
    input  wire              wr_en,
    input  wire  [WIDTH-1:0] wr_data,
    output logic             wr_full,

    input  wire              rd_clk,
    input  wire              rd_rst,
    input  wire              rd_en,
    output logic [WIDTH-1:0] rd_data,
    output logic             rd_empty
);

    // Pointers carry one extra wrap bit
    logic [WIDTH-1:0]    mem [0:(1 << DEPTH_LOG2) - 1];

    logic [DEPTH_LOG2:0] wr_bin;
    logic [DEPTH_LOG2:0] wr_gray;
    logic [DEPTH_LOG2:0] wr_bin_next;
    logic [DEPTH_LOG2:0] wr_gray_next;
    logic [DEPTH_LOG2:0] rd_gray_s1;
    logic [DEPTH_LOG2:0] rd_gray_s2;
    logic                wr_inc;

    logic [DEPTH_LOG2:0] rd_bin;
    logic [DEPTH_LOG2:0] rd_gray;
    logic [DEPTH_LOG2:0] rd_bin_next;
    logic [DEPTH_LOG2:0] rd_gray_next;
    logic [DEPTH_LOG2:0] wr_gray_s1;
    logic [DEPTH_LOG2:0] wr_gray_s2;
    logic                rd_inc;

    function automatic logic [DEPTH_LOG2:0] bin2gray(input logic [DEPTH_LOG2:0] b);
        return b ^ (b >> 1);
    endfunction

    // Write domain
    assign wr_inc       = wr_en && !wr_full;
    assign wr_bin_next  = wr_bin + {{DEPTH_LOG2{1'b0}}, wr_inc};
    assign wr_gray_next = bin2gray(wr_bin_next);

    always_ff @(posedge wr_clk) begin
        if (wr_inc) begin
            mem[wr_bin[DEPTH_LOG2-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_rst) begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
            wr_full    <= 1'b0;
        end else begin
            wr_bin     <= wr_bin_next;
            wr_gray    <= wr_gray_next;
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
            // Full when the next pointer laps the synced read pointer
            wr_full    <= (wr_gray_next == {~rd_gray_s2[DEPTH_LOG2:DEPTH_LOG2-1],
                                            rd_gray_s2[DEPTH_LOG2-2:0]});
        end
    end

    // Read domain
    assign rd_inc       = rd_en && !rd_empty;
    assign rd_bin_next  = rd_bin + {{DEPTH_LOG2{1'b0}}, rd_inc};
    assign rd_gray_next = bin2gray(rd_bin_next);

    always_ff @(posedge rd_clk) begin
        if (rd_inc) begin
            rd_data <= mem[rd_bin[DEPTH_LOG2-1:0]];
        end
    end

    always_ff @(posedge rd_clk) begin
        if (rd_rst) begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
            rd_empty   <= 1'b1;
        end else begin
            rd_bin     <= rd_bin_next;
            rd_gray    <= rd_gray_next;
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
            rd_empty   <= (rd_gray_next == wr_gray_s2);
        end
    end

    // The channel logic must respect both flags
    a_no_write_when_full: assert property (
        @(posedge wr_clk) disable iff (wr_rst) !(wr_en && wr_full)
    ) else $error("async_fifo written while full");

    a_no_read_when_empty: assert property (
        @(posedge rd_clk) disable iff (rd_rst) !(rd_en && rd_empty)
    ) else $error("async_fifo read while empty");

endmodule

`default_nettype wire

// ==== bridge_pkg.sv ====
`default_nettype none

package bridge_pkg;

    // Every crossing FIFO holds 2**3 entries
    localparam int FIFO_DEPTH_LOG2 = 3;

    // One burst request shared by write and read address channels
    typedef struct packed {
        logic [31:0] addr;
        // Beats minus one
        logic [7:0]  len;
        logic [1:0]  id;
    } addr_req_t;

    // One write data beat
    typedef struct packed {
        logic [1:0]  id;
        logic [3:0]  strb;
        logic        last;
        logic [31:0] data;
    } wr_beat_t;

    // One read data beat travelling from bus to master
    typedef struct packed {
        logic [1:0]  id;
        logic        last;
        logic [31:0] data;
    } rd_beat_t;

    // Show-ahead output stage of a channel
    typedef enum logic {
        OUT_EMPTY,
        OUT_HOLD
    } out_state_e;

endpackage

`default_nettype wire
